// ==== sim/cacheTop_properties.sv ====
// ############################
// handshake assertions bound into cacheTop
// ############################
`timescale 1ns/1ps

module cacheTop_properties (
    input logic            clk,
    input logic            reset,
    input logic            cpuDone,
    input cachePkg::busOpT busOut,
    input logic            memReq,
    input logic            memWrite,
    input cachePkg::addrT  memAddr,
    input cachePkg::wordT  memWData,
    input logic            memDone
);
    import cachePkg::*;

    int failCount = 0;

    // request and its fields stay put until memory answers
    memReqHeld: assert property (@(posedge clk) disable iff (reset)
        memReq && !memDone |=> memReq && $stable({memWrite, memAddr, memWData}))
        else begin
            failCount++;
            $error("memReq dropped or its fields changed before memDone");
        end

    cpuDonePulse: assert property (@(posedge clk) disable iff (reset)
        cpuDone |=> !cpuDone)
        else begin
            failCount++;
            $error("cpuDone high for more than one cycle");
        end

    busOutPulse: assert property (@(posedge clk) disable iff (reset)
        busOut != busNone |=> busOut == busNone)  // broadcasts are single pulses
        else begin
            failCount++;
            $error("busOut active for two cycles in a row");
        end

endmodule

bind cacheTop cacheTop_properties props_i (.*);

// ==== sim/cacheTop_tb.sv ====
// ############################
// testbench with clock, reset, memory model,
// step table, MSI reference model and checks
// ############################
`timescale 1ns/1ps

module cacheTop_tb;
    import cachePkg::*;

    typedef struct packed {
        logic       snoop;   // op is a busOpT when set
        logic [1:0] op;
        addrT       addr;
        wordT       wdata;
        busOpT      expBus;
        logic [1:0] expMem;  // memory transactions in the step
    } stepT;

    logic  clk;
    logic  reset = 1'b1;
    cpuOpT cpuOp = cpuIdle;
    addrT  cpuAddr = '0;
    wordT  cpuWData = '0;
    logic  cpuDone;
    wordT  cpuRData;
    busOpT busOut;
    addrT  busOutAddr;
    busOpT snoopOp = busNone;
    addrT  snoopAddr = '0;
    logic  memReq;
    logic  memWrite;
    addrT  memAddr;
    wordT  memWData;
    logic  memDone = 1'b0;
    wordT  memRData = '0;

    stepT        steps[$];
    wordT        memArray [0:255];
    wordT        refMem [0:255];
    lineStateT   refState = lineInvalid;
    addrT        refTag = '0;
    wordT        refData = '0;
    logic [31:0] lcgState = 32'hdc941c62;
    logic [1:0]  memWait = 2'd0;
    logic        memPending = 1'b0;
    int          memOps = 0;
    addrT        lastWbAddr;
    wordT        lastWbData;
    int          busPulses = 0;
    busOpT       lastBus;
    addrT        lastBusAddr;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit;

    cacheTop cacheTop_i (.*);

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory model waits a random time, then pulses memDone
    always @(posedge clk) begin
        memDone <= 1'b0;
        if (memReq && !memDone) begin
            if (!memPending) begin
                lcgState = lcgNext(lcgState);
                memWait    <= lcgState[17:16];
                memPending <= 1'b1;
            end else if (memWait != 2'd0) begin
                memWait <= memWait - 2'd1;
            end else begin
                memPending <= 1'b0;
                memDone    <= 1'b1;
                memOps     <= memOps + 1;
                if (memWrite) begin
                    memArray[memAddr[7:0]] <= memWData;
                    lastWbAddr <= memAddr;
                    lastWbData <= memWData;
                end else begin
                    memRData <= memArray[memAddr[7:0]];
                end
            end
        end
    end

    // bus broadcasts and the run limit
    always @(posedge clk) begin
        if (!reset) begin
            if (busOut != busNone) begin
                busPulses++;
                lastBus     = busOut;
                lastBusAddr = busOutAddr;
            end
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("Timeout: DUT still busy after %0d cycles", cycleCount);
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

    // one-line MSI model advanced before each step
    task automatic predict(input stepT s, output wordT expData, output logic expWb,
                           output addrT wbAddr, output wordT wbData);
        logic hit;
        hit    = (refState != lineInvalid) && (refTag == s.addr);
        expWb  = 1'b0;
        wbAddr = refTag;
        wbData = refData;
        if (s.snoop) begin
            if (hit && refState == lineModified) begin
                expWb    = 1'b1;
                refState = (busOpT'(s.op) == busReadMiss) ? lineShared : lineInvalid;
            end else if (hit && busOpT'(s.op) != busReadMiss) begin
                refState = lineInvalid;
            end
        end else begin
            if (!hit) begin
                expWb    = (refState == lineModified);  // victim goes out first
                refTag   = s.addr;
                refData  = refMem[s.addr[7:0]];
                refState = lineShared;
            end
            if (cpuOpT'(s.op) == cpuWrite) begin
                refData  = s.wdata;
                refState = lineModified;
            end
        end
        if (expWb) refMem[wbAddr[7:0]] = wbData;
        expData = refData;
    endtask

    task automatic runStep(input stepT s);
        int   startOps;
        int   waitCycles;
        wordT expData;
        logic expWb;
        addrT wbAddr;
        wordT wbData;
        predict(s, expData, expWb, wbAddr, wbData);
        startOps  = memOps;
        busPulses = 0;
        @(posedge clk);
        if (s.snoop) begin
            snoopOp   <= busOpT'(s.op);
            snoopAddr <= s.addr;
            @(posedge clk);
            snoopOp <= busNone;
            while (memOps - startOps < s.expMem) @(negedge clk);
            repeat (3) @(posedge clk);  // done to the FSM, then line update
        end else begin
            cpuOp    <= cpuOpT'(s.op);
            cpuAddr  <= s.addr;
            cpuWData <= s.wdata;
            waitCycles = 0;
            do begin
                @(negedge clk);
                waitCycles++;
            end while (!cpuDone);
            if (cpuOpT'(s.op) == cpuRead) checkEqual("read data", cpuRData, expData);
            if (s.expMem == 0) begin
                checkEqual("cycles to cpuDone", waitCycles, 2);
                checkEqual("memReq on a hit", memReq, 1'b0);
            end
            if (s.expBus == busInvalidate) checkEqual("busOut with cpuDone", busOut, busInvalidate);
            @(posedge clk);
            cpuOp <= cpuIdle;
        end
        @(negedge clk);
        checkEqual("memory transactions", memOps - startOps, s.expMem);
        checkEqual("broadcast pulses", busPulses, (s.expBus != busNone) ? 1 : 0);
        if (s.expBus != busNone) begin
            checkEqual("broadcast op", lastBus, s.expBus);
            checkEqual("broadcast address", lastBusAddr, s.addr);
        end
        if (expWb) begin
            checkEqual("write-back address", lastWbAddr, wbAddr);
            checkEqual("write-back data", lastWbData, wbData);
        end
    endtask

    task automatic addStep(input logic snoop, input logic [1:0] op, input addrT addr,
                           input wordT wdata, input busOpT expBus, input logic [1:0] expMem);
        steps.push_back({snoop, op, addr, wdata, expBus, expMem});
    endtask

    initial begin
        for (int a = 0; a < 256; a++) begin
            memArray[a] = {a[7:0] ^ 8'h5a, ~a[7:0], a[7:0], 8'hc3 ^ a[7:0]};
            refMem[a]   = memArray[a];
        end
        //      snoop op             addr      wdata          expBus         mem
        addStep(1'b0, cpuRead,       16'h0012, 32'h0,         busReadMiss,   2'd1);
        addStep(1'b0, cpuRead,       16'h0012, 32'h0,         busNone,       2'd0);
        addStep(1'b0, cpuWrite,      16'h0012, 32'h1111_aaaa, busInvalidate, 2'd0);
        addStep(1'b0, cpuRead,       16'h0012, 32'h0,         busNone,       2'd0);
        addStep(1'b0, cpuRead,       16'h0034, 32'h0,         busReadMiss,   2'd2);
        addStep(1'b0, cpuWrite,      16'h0056, 32'h2222_bbbb, busWriteMiss,  2'd1);
        addStep(1'b0, cpuWrite,      16'h0056, 32'h3333_cccc, busNone,       2'd0);
        addStep(1'b1, busReadMiss,   16'h0056, 32'h0,         busNone,       2'd1);
        addStep(1'b0, cpuRead,       16'h0056, 32'h0,         busNone,       2'd0);
        addStep(1'b1, busWriteMiss,  16'h0056, 32'h0,         busNone,       2'd0);
        addStep(1'b0, cpuRead,       16'h0056, 32'h0,         busReadMiss,   2'd1);
        addStep(1'b1, busInvalidate, 16'h0056, 32'h0,         busNone,       2'd0);
        addStep(1'b0, cpuRead,       16'h0056, 32'h0,         busReadMiss,   2'd1);
        addStep(1'b0, cpuWrite,      16'h0012, 32'h4444_dddd, busWriteMiss,  2'd1);
        addStep(1'b1, busWriteMiss,  16'h0012, 32'h0,         busNone,       2'd1);
        addStep(1'b0, cpuRead,       16'h0012, 32'h0,         busReadMiss,   2'd1);
        addStep(1'b1, busReadMiss,   16'h0034, 32'h0,         busNone,       2'd0);
        addStep(1'b0, cpuWrite,      16'h0034, 32'h5555_eeee, busWriteMiss,  2'd1);
        addStep(1'b0, cpuRead,       16'h0012, 32'h0,         busReadMiss,   2'd2);
        cycleLimit = steps.size() * 20;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkEqual("cpuDone after reset", cpuDone, 1'b0);
        checkEqual("memReq after reset", memReq, 1'b0);
        checkEqual("busOut after reset", busOut, busNone);
        foreach (steps[i]) runStep(steps[i]);
        errorCount += cacheTop_i.props_i.failCount;
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== source/cacheIfs.sv ====
// ############################
// line-store interface and
// memory-request interface
// ############################
`timescale 1ns/1ps

interface lineIf;
    import cachePkg::*;

    // load request from the controller
    logic      update;
    lineStateT newState;
    addrT      newTag;
    wordT      newData;

    // current contents and compare results
    lineStateT state;
    addrT      tag;
    wordT      data;
    logic      cpuHit;
    logic      snoopHit;

    modport ctrl (
        output update, newState, newTag, newData,
        input  state, tag, data, cpuHit, snoopHit
    );

    modport store (
        input  update, newState, newTag, newData,
        output state, tag, data, cpuHit, snoopHit
    );

endinterface

interface memIf;
    import cachePkg::*;

    logic start;  // one-cycle pulse
    logic write;
    addrT addr;
    wordT wdata;
    logic busy;
    logic done;   // one-cycle pulse with rdata valid
    wordT rdata;

    modport ctrl (
        output start, write, addr, wdata,
        input  busy, done, rdata
    );

    modport port (
        input  start, write, addr, wdata,
        output busy, done, rdata
    );

endinterface

// ==== source/cacheLineStore.sv ====
// ############################
// single cache line: state, tag, data
// and the CPU and snoop hit compares
// ############################
`timescale 1ns/1ps

module cacheLineStore (
    input  logic           clk,
    input  logic           reset,
    input  cachePkg::addrT cpuAddr,
    input  cachePkg::addrT snoopAddr,
    lineIf.store           line
);
    import cachePkg::*;

    lineStateT state;
    addrT      tag;
    wordT      data;
    logic      valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lineInvalid;
            tag   <= '0;
        end else if (line.update) begin
            state <= line.newState;
            tag   <= line.newTag;
        end
    end

    // data word itself
    always_ff @(posedge clk) begin
        if (line.update) begin
            data <= line.newData;
        end
    end

    assign valid = (state != lineInvalid);

    assign line.state    = state;
    assign line.tag      = tag;
    assign line.data     = data;
    assign line.cpuHit   = valid && (tag == cpuAddr);
    assign line.snoopHit = valid && (tag == snoopAddr);  // qualified by snoopOp in the ctrl

endmodule

// ==== source/cachePkg.sv ====
// ############################
// widths, word and address types,
// CPU and bus opcodes, line and controller states
// ############################
package cachePkg;

    localparam int addrWidth = 16;  // one word per address
    localparam int wordWidth = 32;

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [wordWidth-1:0] wordT;

    // request from the processor
    typedef enum logic [1:0] {
        cpuIdle  = 2'd0,
        cpuRead  = 2'd1,
        cpuWrite = 2'd2
    } cpuOpT;

    // messages seen on the shared bus
    typedef enum logic [1:0] {
        busNone       = 2'd0,
        busReadMiss   = 2'd1,
        busWriteMiss  = 2'd2,
        busInvalidate = 2'd3
    } busOpT;

    typedef enum logic [1:0] {
        lineInvalid  = 2'd0,
        lineShared   = 2'd1,
        lineModified = 2'd2
    } lineStateT;

    typedef enum logic [1:0] {
        ctrlReady     = 2'd0,
        ctrlWriteBack = 2'd1,  // old line or snooped line going to memory
        ctrlFetch     = 2'd2,  // refill after a miss
        ctrlRespond   = 2'd3   // cpuDone cycle
    } ctrlStateT;

endpackage

// ==== source/cacheTop.sv ====
// ############################
// snooping MSI cache, top level
// ############################
`timescale 1ns/1ps

module cacheTop (
    input  logic             clk,
    input  logic             reset,

    // CPU side
    input  cachePkg::cpuOpT  cpuOp,
    input  cachePkg::addrT   cpuAddr,
    input  cachePkg::wordT   cpuWData,
    output logic             cpuDone,
    output cachePkg::wordT   cpuRData,

    // shared bus
    output cachePkg::busOpT  busOut,
    output cachePkg::addrT   busOutAddr,
    input  cachePkg::busOpT  snoopOp,
    input  cachePkg::addrT   snoopAddr,

    // memory
    output logic             memReq,
    output logic             memWrite,
    output cachePkg::addrT   memAddr,
    output cachePkg::wordT   memWData,
    input  logic             memDone,
    input  cachePkg::wordT   memRData
);

    lineIf lineBus ();
    memIf  memBus ();

    cacheLineStore lineStore_i (
        .clk       (clk),
        .reset     (reset),
        .cpuAddr   (cpuAddr),
        .snoopAddr (snoopAddr),
        .line      (lineBus.store)
    );

    coherenceController ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .cpuOp      (cpuOp),
        .cpuWData   (cpuWData),
        .cpuAddr    (cpuAddr),
        .snoopOp    (snoopOp),
        .cpuDone    (cpuDone),
        .cpuRData   (cpuRData),
        .busOut     (busOut),
        .busOutAddr (busOutAddr),
        .line       (lineBus.ctrl),
        .mem        (memBus.ctrl)
    );

    memPort memPort_i (
        .clk      (clk),
        .reset    (reset),
        .mem      (memBus.port),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memDone  (memDone),
        .memRData (memRData)
    );

endmodule

// ==== source/coherenceController.sv ====
// ############################
// MSI controller FSM: hits, misses,
// snoops, bus broadcasts, memory traffic
// ############################
`timescale 1ns/1ps

module coherenceController (
    input  logic             clk,
    input  logic             reset,
    input  cachePkg::cpuOpT  cpuOp,
    input  cachePkg::wordT   cpuWData,
    input  cachePkg::addrT   cpuAddr,
    input  cachePkg::busOpT  snoopOp,
    output logic             cpuDone,
    output cachePkg::wordT   cpuRData,
    output cachePkg::busOpT  busOut,
    output cachePkg::addrT   busOutAddr,
    lineIf.ctrl              line,
    memIf.ctrl               mem
);
    import cachePkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;
    logic      snoopWb;      // current write-back was forced by a snoop
    logic      snoopWbNext;
    lineStateT wbState;      // where the line goes after a snoop write-back
    lineStateT wbStateNext;
    logic      cpuDoneNext;
    wordT      cpuRDataNext;
    busOpT     busOutNext;
    addrT      busOutAddrNext;
    logic      snoopAct;

    assign snoopAct = line.snoopHit && (snoopOp != busNone);

    always_comb begin
        stateNext      = state;
        snoopWbNext    = snoopWb;
        wbStateNext    = wbState;
        cpuDoneNext    = 1'b0;
        cpuRDataNext   = cpuRData;
        busOutNext     = busNone;  // broadcasts are single pulses
        busOutAddrNext = busOutAddr;
        line.update    = 1'b0;
        line.newState  = line.state;
        line.newTag    = line.tag;
        line.newData   = line.data;
        mem.start      = 1'b0;
        mem.write      = 1'b0;
        mem.addr       = line.tag;   // write-back of the held line
        mem.wdata      = line.data;

        case (state)
            ctrlReady: begin
                if (snoopAct) begin
                    // snoop wins, CPU request waits
                    if (line.state == lineModified) begin
                        mem.start   = 1'b1;
                        mem.write   = 1'b1;
                        snoopWbNext = 1'b1;
                        wbStateNext = (snoopOp == busReadMiss) ? lineShared : lineInvalid;
                        stateNext   = ctrlWriteBack;
                    end else if (snoopOp != busReadMiss) begin
                        line.update   = 1'b1;
                        line.newState = lineInvalid;
                    end
                end else if (cpuOp == cpuRead && line.cpuHit) begin
                    cpuDoneNext  = 1'b1;
                    cpuRDataNext = line.data;
                    stateNext    = ctrlRespond;
                end else if (cpuOp == cpuWrite && line.cpuHit) begin
                    line.update   = 1'b1;
                    line.newState = lineModified;
                    line.newData  = cpuWData;
                    if (line.state == lineShared) begin
                        busOutNext     = busInvalidate;  // other sharers drop their copy
                        busOutAddrNext = cpuAddr;
                    end
                    cpuDoneNext = 1'b1;
                    stateNext   = ctrlRespond;
                end else if (cpuOp != cpuIdle && !mem.busy) begin
                    busOutNext     = (cpuOp == cpuWrite) ? busWriteMiss : busReadMiss;
                    busOutAddrNext = cpuAddr;
                    snoopWbNext    = 1'b0;
                    mem.start      = 1'b1;
                    if (line.state == lineModified) begin
                        mem.write = 1'b1;  // dirty victim first
                        stateNext = ctrlWriteBack;
                    end else begin
                        mem.addr  = cpuAddr;
                        stateNext = ctrlFetch;
                    end
                end
            end

            ctrlWriteBack: begin
                if (mem.done) begin
                    if (snoopWb) begin
                        line.update   = 1'b1;
                        line.newState = wbState;
                        stateNext     = ctrlReady;
                    end else begin
                        mem.start = 1'b1;
                        mem.addr  = cpuAddr;  // CPU holds its request during the miss
                        stateNext = ctrlFetch;
                    end
                end
            end

            ctrlFetch: begin
                if (mem.done) begin
                    line.update = 1'b1;
                    line.newTag = cpuAddr;
                    if (cpuOp == cpuWrite) begin
                        line.newState = lineModified;
                        line.newData  = cpuWData;
                    end else begin
                        line.newState = lineShared;
                        line.newData  = mem.rdata;
                        cpuRDataNext  = mem.rdata;
                    end
                    cpuDoneNext = 1'b1;
                    stateNext   = ctrlRespond;
                end
            end

            ctrlRespond: stateNext = ctrlReady;  // CPU not sampled here

            default: stateNext = ctrlReady;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ctrlReady;
            snoopWb <= 1'b0;
            wbState <= lineInvalid;
            cpuDone <= 1'b0;
            busOut  <= busNone;
        end else begin
            state   <= stateNext;
            snoopWb <= snoopWbNext;
            wbState <= wbStateNext;
            cpuDone <= cpuDoneNext;
            busOut  <= busOutNext;
        end
    end

    always_ff @(posedge clk) begin
        cpuRData   <= cpuRDataNext;
        busOutAddr <= busOutAddrNext;
    end

endmodule

// ==== source/memPort.sv ====
// ############################
// memory request register and
// request/done handshake
// ############################
`timescale 1ns/1ps

module memPort (
    input  logic           clk,
    input  logic           reset,
    memIf.port             mem,
    output logic           memReq,
    output logic           memWrite,
    output cachePkg::addrT memAddr,
    output cachePkg::wordT memWData,
    input  logic           memDone,
    input  cachePkg::wordT memRData
);
    import cachePkg::*;

    logic reqActive;
    logic writeReg;
    logic doneReg;
    addrT addrReg;
    wordT wdataReg;
    wordT rdataReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            reqActive <= 1'b0;
            writeReg  <= 1'b0;
            doneReg   <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            if (reqActive) begin
                if (memDone) begin
                    reqActive <= 1'b0;
                    doneReg   <= 1'b1;  // one cycle behind memDone
                end
            end else if (mem.start) begin
                reqActive <= 1'b1;
                writeReg  <= mem.write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reqActive && mem.start) begin
            addrReg  <= mem.addr;
            wdataReg <= mem.wdata;
        end
        if (reqActive && memDone) begin
            rdataReg <= memRData;
        end
    end

    assign memReq   = reqActive;  // fields stay put until memDone
    assign memWrite = writeReg;
    assign memAddr  = addrReg;
    assign memWData = wdataReg;

    assign mem.busy  = reqActive;
    assign mem.done  = doneReg;
    assign mem.rdata = rdataReg;

endmodule

// ==== src.f ====
source/cachePkg.sv
source/cacheIfs.sv
source/cacheLineStore.sv
source/coherenceController.sv
source/memPort.sv
source/cacheTop.sv
sim/cacheTop_properties.sv
sim/cacheTop_tb.sv
